//--- tb.f
div_msg_pkg.sv
div_ctrl_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
int_div_sva.sv
int_div_tb.sv

//--- int_div_tb.sv
/*
  testbench for the iterative divider: clock, reset, request
  stimulus, response sink with random stalls and a timeout
*/
module int_div_tb;

  localparam int WIDTH        = 32;
  localparam int reset_cycles = 10;
  localparam int num_directed = 14;
  localparam int num_random   = 200;
  // per request: WIDTH+1 latency, up to 5 stall cycles, one idle cycle
  localparam int timeout_cycles =
    (num_directed + num_random) * (WIDTH + 8) + reset_cycles + 100;

  localparam logic [WIDTH-1:0] all_ones = {WIDTH{1'b1}};
  localparam logic [WIDTH-1:0] most_neg = {1'b1, {(WIDTH-1){1'b0}}};

  logic                 clk;
  logic                 reset;
  div_msg_pkg::div_fn_e req_fn;
  logic [WIDTH-1:0]     req_a;
  logic [WIDTH-1:0]     req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [2*WIDTH-1:0]   resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  integer seed;
  int     req_count   = 0;
  int     resp_count  = 0;
  int     errors      = 0;
  int     cycle_count = 0;
  // stall cycles left for the pending response
  int     hold_left   = 0;

  int_div_iterative #(
    .WIDTH       (WIDTH)
  ) i_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // checks ride along inside the DUT, state comes from the controller
  bind int_div_iterative int_div_sva #(
    .WIDTH       (WIDTH)
  ) i_int_div_sva (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .state       (i_int_div_ctrl.state)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // --------------------
  // response sink
  // --------------------

  // stall counts down only while a response waits
  always @(negedge clk) begin
    if (reset) begin
      resp_rdy = 1'b0;
    end else begin
      resp_rdy = (hold_left == 0);
      if (resp_val && hold_left > 0) begin
        hold_left = hold_left - 1;
      end
    end
  end

  // count transfers, draw the stall for the next response, watch the time
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (!reset && resp_val && resp_rdy) begin
      resp_count = resp_count + 1;
      hold_left  = $unsigned($random(seed)) % 6;
    end
    if (cycle_count >= timeout_cycles) begin
      $display("error: run did not finish within %0d cycles", timeout_cycles);
      $display("requests %0d responses %0d errors %0d", req_count, resp_count, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  // request source
  // --------------------

  // called at a falling edge, returns at the falling edge after the accept
  task automatic send_request(
    input div_msg_pkg::div_fn_e fn,
    input logic [WIDTH-1:0]     a,
    input logic [WIDTH-1:0]     b
  );
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    // req_rdy is settled at the falling edge
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_count = req_count + 1;
  endtask

  initial begin : stimulus
    logic [WIDTH-1:0]     a;
    logic [WIDTH-1:0]     b;
    div_msg_pkg::div_fn_e fn;
    int                   waited;
    int                   total_fail;
    seed     = 32'h1ab6ee2f;
    reset    = 1'b1;
    req_fn   = div_msg_pkg::fn_divu;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    // unsigned corners, divide by zero last
    send_request(div_msg_pkg::fn_divu, WIDTH'(0), WIDTH'(7));
    send_request(div_msg_pkg::fn_divu, WIDTH'(5), WIDTH'(9));
    send_request(div_msg_pkg::fn_divu, all_ones, WIDTH'(3));
    send_request(div_msg_pkg::fn_divu, WIDTH'(12345), WIDTH'(1));
    send_request(div_msg_pkg::fn_divu, all_ones, all_ones);
    send_request(div_msg_pkg::fn_divu, WIDTH'(100), WIDTH'(0));
    // all four sign combinations
    send_request(div_msg_pkg::fn_div, WIDTH'(100), WIDTH'(7));
    send_request(div_msg_pkg::fn_div, WIDTH'(-100), WIDTH'(7));
    send_request(div_msg_pkg::fn_div, WIDTH'(100), WIDTH'(-7));
    send_request(div_msg_pkg::fn_div, WIDTH'(-100), WIDTH'(-7));
    // overflow case wraps back to most negative
    send_request(div_msg_pkg::fn_div, most_neg, all_ones);
    send_request(div_msg_pkg::fn_div, most_neg, WIDTH'(1));
    send_request(div_msg_pkg::fn_div, WIDTH'(-5), WIDTH'(0));
    send_request(div_msg_pkg::fn_div, WIDTH'(5), WIDTH'(0));

    // random operands, divisor shifted down for larger quotients
    for (int i = 0; i < num_random; i++) begin
      fn = div_msg_pkg::div_fn_e'($random(seed) & 1);
      a  = WIDTH'($random(seed));
      b  = WIDTH'($random(seed)) >> ($unsigned($random(seed)) % WIDTH);
      send_request(fn, a, b);
      // sometimes drop req_val for a cycle
      if ($random(seed) & 1) begin
        req_val = 1'b0;
        @(negedge clk);
      end
    end
    req_val = 1'b0;

    // last response may still be stalled
    waited = 0;
    while (resp_count < req_count && waited < WIDTH + 10) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (resp_count < req_count) begin
      $display("error: no response arrived for %0d of %0d requests",
        req_count - resp_count, req_count);
      errors = errors + 1;
    end
    if (resp_count != req_count) begin
      $display("mismatch at time %0t: %0d responses for %0d requests",
        $time, resp_count, req_count);
      errors = errors + 1;
    end
    repeat (2) @(negedge clk);

    total_fail = errors + i_int_div_iterative.i_int_div_sva.fail_count;
    $display("requests %0d responses %0d assertion failures %0d testbench errors %0d",
      req_count, resp_count, i_int_div_iterative.i_int_div_sva.fail_count, errors);
    if (total_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- int_div_sva.sv
/*
  bound checks for the iterative divider: handshakes, latency
  and result values against a model of the division rules
*/
module int_div_sva #(
  parameter int WIDTH = 32
) (
  input logic                     clk,
  input logic                     reset,
  input div_msg_pkg::div_fn_e     req_fn,
  input logic [WIDTH-1:0]         req_a,
  input logic [WIDTH-1:0]         req_b,
  input logic                     req_val,
  input logic                     req_rdy,
  input logic [2*WIDTH-1:0]       resp_result,
  input logic                     resp_val,
  input logic                     resp_rdy,
  // controller state, taken from inside the DUT
  input div_ctrl_pkg::div_state_e state
);

  // failed checks, read by the testbench at the end
  int fail_count = 0;

  // --------------------
  // reference model
  // --------------------

  // magnitudes first, then quotient sign from both operands, remainder sign from a
  function automatic logic [2*WIDTH-1:0] expected_result(
    input div_msg_pkg::div_fn_e fn,
    input logic [WIDTH-1:0]     a,
    input logic [WIDTH-1:0]     b
  );
    logic             a_sgn;
    logic             b_sgn;
    logic [WIDTH-1:0] a_abs;
    logic [WIDTH-1:0] b_abs;
    logic [WIDTH-1:0] quot;
    logic [WIDTH-1:0] rem;
    a_sgn = (fn == div_msg_pkg::fn_div) && a[WIDTH-1];
    b_sgn = (fn == div_msg_pkg::fn_div) && b[WIDTH-1];
    a_abs = a_sgn ? WIDTH'(0) - a : a;
    b_abs = b_sgn ? WIDTH'(0) - b : b;
    // zero divisor: every quotient bit is 1, dividend left over
    if (b_abs == '0) begin
      quot = '1;
      rem  = a_abs;
    end else begin
      quot = a_abs / b_abs;
      rem  = a_abs % b_abs;
    end
    if (a_sgn != b_sgn) begin
      quot = WIDTH'(0) - quot;
    end
    if (a_sgn) begin
      rem = WIDTH'(0) - rem;
    end
    return {rem, quot};
  endfunction

  // expected word, captured on the accept edge
  logic [2*WIDTH-1:0] exp_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      exp_result <= '0;
    end else if (req_val && req_rdy) begin
      exp_result <= expected_result(req_fn, req_a, req_b);
    end
  end

  // --------------------
  // handshake checks
  // --------------------

  // first edge out of reset
  a_reset_state: assert property (@(posedge clk) $fell(reset) |-> req_rdy && !resp_val)
    else begin
      $error("divider not idle after reset");
      fail_count++;
    end

  a_rdy_excl: assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
    else begin
      $error("req_rdy high while a response is pending");
      fail_count++;
    end

  // one st_calc cycle per quotient bit, then st_done
  a_calc_len: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> (state == div_ctrl_pkg::st_calc) [*WIDTH]
      ##1 (state == div_ctrl_pkg::st_done))
    else begin
      $error("FSM did not spend WIDTH cycles in st_calc");
      fail_count++;
    end

  // WIDTH quiet edges, then resp_val
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> (!resp_val) [*WIDTH] ##1 resp_val)
    else begin
      $error("response latency differs from WIDTH+1");
      fail_count++;
    end

  a_no_orphan: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_val && req_rdy, WIDTH + 1))
    else begin
      $error("response without a matching accept");
      fail_count++;
    end

  // --------------------
  // result checks
  // --------------------

  a_result: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> resp_result == exp_result)
    else begin
      $error("result differs from model");
      fail_count++;
    end

  // stall holds the word
  a_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      $error("response changed under back-pressure");
      fail_count++;
    end

  a_release: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |=> req_rdy)
    else begin
      $error("req_rdy not back after response transfer");
      fail_count++;
    end

endmodule

//--- int_div_iterative.sv
/*
  iterative integer divider, one quotient bit per cycle
  joins the handshake controller and the shift-subtract datapath
*/
module int_div_iterative #(
  parameter int WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 reset,

  // --------------------
  // request
  // --------------------

  input  div_msg_pkg::div_fn_e req_fn,
  input  logic [WIDTH-1:0]     req_a,
  input  logic [WIDTH-1:0]     req_b,
  input  logic                 req_val,
  output logic                 req_rdy,

  // --------------------
  // response
  // --------------------

  // remainder in the upper half, quotient in the lower half
  output logic [2*WIDTH-1:0]   resp_result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // control to datapath
  logic load;
  logic iterate;
  // datapath to control
  logic count_zero;

  // handshake FSM
  int_div_ctrl #(
    .WIDTH      (WIDTH)
  ) i_int_div_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .load       (load),
    .iterate    (iterate),
    .count_zero (count_zero)
  );

  // operand registers, divide step and sign correction
  int_div_dpath #(
    .WIDTH       (WIDTH)
  ) i_int_div_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .iterate     (iterate),
    .count_zero  (count_zero),
    .resp_result (resp_result)
  );

endmodule

//--- int_div_ctrl.sv
/*
  iterative divider control: three-state FSM for the val/rdy
  handshakes and the datapath load and iterate strobes
*/
module int_div_ctrl #(
  parameter int WIDTH = 32
) (
  input  logic clk,
  input  logic reset,

  // request side
  input  logic req_val,
  output logic req_rdy,

  // response side
  output logic resp_val,
  input  logic resp_rdy,

  // datapath strobes and status
  output logic load,
  output logic iterate,
  input  logic count_zero
);

  // --------------------
  // width check
  // --------------------

  // the datapath counter needs at least one bit of range below WIDTH
  if (WIDTH < 2) begin : g_width_check
    $fatal(1, "int_div_ctrl: WIDTH must be at least 2");
  end

  // --------------------
  // state register
  // --------------------

  div_ctrl_pkg::div_state_e state;
  div_ctrl_pkg::div_state_e state_next;

  // handshake events
  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_ctrl_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      div_ctrl_pkg::st_idle: begin
        // operands and counter load on this same edge
        if (req_go) begin
          state_next = div_ctrl_pkg::st_calc;
        end
      end
      div_ctrl_pkg::st_calc: begin
        // counter at zero marks the last quotient bit
        if (count_zero) begin
          state_next = div_ctrl_pkg::st_done;
        end
      end
      div_ctrl_pkg::st_done: begin
        // hold the result until the sink takes it
        if (resp_go) begin
          state_next = div_ctrl_pkg::st_idle;
        end
      end
      default: begin
        state_next = div_ctrl_pkg::st_idle;
      end
    endcase
  end

  // --------------------
  // output decode
  // --------------------

  // all outputs are pure decodes of state
  assign req_rdy  = (state == div_ctrl_pkg::st_idle);
  assign resp_val = (state == div_ctrl_pkg::st_done);
  assign iterate  = (state == div_ctrl_pkg::st_calc);
  // one-cycle pulse, only in the accept cycle
  assign load     = req_val & (state == div_ctrl_pkg::st_idle);

endmodule

//--- int_div_dpath.sv
/*
  iterative divider datapath: operand normalization, restoring
  shift-subtract register, iteration counter and sign correction
*/
module int_div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    reset,

  // request fields, sampled on load
  input  div_msg_pkg::div_fn_e    req_fn,
  input  logic [WIDTH-1:0]        req_a,
  input  logic [WIDTH-1:0]        req_b,

  // strobes from the controller
  input  logic                    load,
  input  logic                    iterate,

  // status back to the controller
  output logic                    count_zero,

  // remainder in the upper slot, quotient in the lower slot
  output logic [2*WIDTH-1:0]      resp_result
);

  // counter has to hold WIDTH-1
  localparam int cnt_w = (WIDTH > 2) ? $clog2(WIDTH) : 1;

  // --------------------
  // registers
  // --------------------

  // remainder/quotient register, one spare bit on top for the sign of the difference
  logic [2*WIDTH:0] rq_reg;
  // divisor magnitude, aligned with the remainder half
  logic [2*WIDTH:0] div_reg;
  logic [cnt_w-1:0] count_reg;
  // output correction flags, captured with the operands
  logic             neg_quot_reg;
  logic             neg_rem_reg;

  // --------------------
  // operand normalization
  // --------------------

  logic             is_signed;
  logic             a_neg;
  logic             b_neg;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;

  always_comb begin
    is_signed = (req_fn == div_msg_pkg::fn_div);
    // sign bits only matter for the signed function
    a_neg = is_signed & req_a[WIDTH-1];
    b_neg = is_signed & req_b[WIDTH-1];
    // two's complement magnitude, most negative value maps onto itself
    a_mag = a_neg ? -req_a : req_a;
    b_mag = b_neg ? -req_b : req_b;
  end

  // --------------------
  // shift-subtract step
  // --------------------

  logic [2*WIDTH:0] rq_shift;
  logic [2*WIDTH:0] rq_diff;
  logic [2*WIDTH:0] rq_next;

  always_comb begin
    // bring in the next dividend bit, low bit opens up for the quotient
    rq_shift = rq_reg << 1;
    rq_diff  = rq_shift - div_reg;
    // top bit set means the divisor did not fit
    if (rq_diff[2*WIDTH]) begin
      // restore, quotient bit stays 0
      rq_next = rq_shift;
    end else begin
      // keep the difference and record a 1
      rq_next = {rq_diff[2*WIDTH:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg       <= '0;
      div_reg      <= '0;
      count_reg    <= '0;
      neg_quot_reg <= 1'b0;
      neg_rem_reg  <= 1'b0;
    end else if (load) begin
      // dividend sits in the quotient half, remainder half starts empty
      rq_reg       <= {{(WIDTH+1){1'b0}}, a_mag};
      div_reg      <= {1'b0, b_mag, {WIDTH{1'b0}}};
      // WIDTH iterations, the last one runs while the counter reads zero
      count_reg    <= cnt_w'(WIDTH - 1);
      // quotient negative when the signs differ
      neg_quot_reg <= a_neg ^ b_neg;
      // remainder follows the dividend
      neg_rem_reg  <= a_neg;
    end else if (iterate) begin
      rq_reg    <= rq_next;
      count_reg <= count_reg - 1'b1;
    end
  end

  assign count_zero = (count_reg == '0);

  // --------------------
  // result correction
  // --------------------

  logic [WIDTH-1:0] quot_mag;
  logic [WIDTH-1:0] rem_mag;

  always_comb begin
    quot_mag = rq_reg[div_msg_pkg::resp_quot_slot*WIDTH +: WIDTH];
    rem_mag  = rq_reg[div_msg_pkg::resp_rem_slot*WIDTH +: WIDTH];
    // registers are idle in st_done so the word stays stable under back-pressure
    resp_result[div_msg_pkg::resp_quot_slot*WIDTH +: WIDTH] =
      neg_quot_reg ? -quot_mag : quot_mag;
    resp_result[div_msg_pkg::resp_rem_slot*WIDTH +: WIDTH] =
      neg_rem_reg ? -rem_mag : rem_mag;
  end

endmodule

//--- div_ctrl_pkg.sv
/*
  divider control definitions: state encoding of the handshake FSM,
  shared by the controller and the bound checks
*/
package div_ctrl_pkg;

  // --------------------
  // controller states
  // --------------------

  // one division in flight at a time, so three states are enough
  typedef enum logic [1:0] {
    // waiting for a request, req_rdy high
    st_idle = 2'd0,
    // one quotient bit per cycle, WIDTH cycles in total
    st_calc = 2'd1,
    // result held until the response side takes it
    st_done = 2'd2
  } div_state_e;

  // 2'd3 is never entered; the FSM falls back to st_idle from it

endpackage

//--- div_msg_pkg.sv
/*
  divider message definitions: request function flag and the
  layout of the response word (remainder over quotient)
*/
package div_msg_pkg;

  // --------------------
  // request function flag
  // --------------------

  // selects how the operands are read
  typedef enum logic {
    // operands taken as plain magnitudes
    fn_divu = 1'b0,
    // two's complement operands, corrected at the output
    fn_div  = 1'b1
  } div_fn_e;

  // --------------------
  // response word layout
  // --------------------

  // the response is two WIDTH-bit slots, slot n starts at bit n*WIDTH
  localparam int resp_quot_slot = 0;
  localparam int resp_rem_slot  = 1;

endpackage
